// ==== Makefile ====
# Verilator build and run for the object engine testbench

VERILATOR ?= verilator
TOP       ?= obj_engine_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(shell cat sources.f)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) sources.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sources.f

# the log search decides pass or fail
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/obj_pkg.sv ====
// object engine package with shared widths, table layout and colour constants
package obj_pkg;

    typedef logic [15:0] vram_word_t;   // vram and table word
    typedef logic [16:0] vram_addr_t;   // vram word address
    typedef logic [ 9:0] frame_addr_t;  // object index + word select
    typedef logic [ 7:0] line_addr_t;   // half + entry + word select
    typedef logic [ 8:0] vpos_t;        // line number
    typedef logic [ 8:0] hpos_t;        // pixel column
    typedef logic [19:0] rom_addr_t;    // tile code + row
    typedef logic [31:0] rom_word_t;    // eight 4bpp pixels
    typedef logic [ 8:0] pxl_t;         // palette in 8:4, colour in 3:0

    localparam int MAX_OBJ       = 256;  // objects per frame
    localparam int LINE_OBJ      = 32;   // objects per line
    localparam int WORDS_PER_OBJ = 4;
    localparam int FRAME_WORDS   = MAX_OBJ * WORDS_PER_OBJ;

    // word order inside a table entry
    localparam logic [1:0] WORD_X    = 2'd0;
    localparam logic [1:0] WORD_Y    = 2'd1;  // row to draw in the line list
    localparam logic [1:0] WORD_CODE = 2'd2;
    localparam logic [1:0] WORD_ATTR = 2'd3;  // pal 4:0, hflip 5, vflip 6

    localparam logic [7:0] END_ATTR = 8'hFF;            // attr high byte, table end
    localparam vram_word_t END_WORD = {END_ATTR, 8'h00};

    localparam logic [3:0] TRANSP_COLOR = 4'd15;  // never drawn
    localparam pxl_t       BLANK_PXL    = '1;     // empty buffer pixel

endpackage

// ==== design/obj_engine.sv ====
// object engine top, frame table to line table to drawer to line buffer
`timescale 1ns/1ps

module obj_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pxl_cen,
    input  logic                vb,
    input  logic                start,      // once per line
    input  obj_pkg::vpos_t      vrender1,   // two lines ahead of vdump
    input  obj_pkg::vpos_t      vdump,
    input  obj_pkg::hpos_t      hdump,
    input  obj_pkg::vram_word_t vram_base,
    output obj_pkg::vram_addr_t vram_addr,
    input  obj_pkg::vram_word_t vram_data,
    input  logic                vram_ok,
    output logic                vram_cs,
    output obj_pkg::rom_addr_t  rom_addr,
    output logic                rom_half,
    input  obj_pkg::rom_word_t  rom_data,
    output logic                rom_cs,
    input  logic                rom_ok,
    output obj_pkg::pxl_t       pxl
);
    import obj_pkg::*;

    frame_addr_t frame_addr;
    vram_word_t  frame_data;
    line_addr_t  line_addr;
    vram_word_t  line_data;
    hpos_t       buf_addr;
    pxl_t        buf_data;
    logic        buf_wr;

    obj_frame_table u_frame (
        .clk        (clk),
        .rst_n      (rst_n),
        .vb         (vb),
        .vram_base  (vram_base),
        .vram_data  (vram_data),
        .vram_ok    (vram_ok),
        .vram_addr  (vram_addr),
        .vram_cs    (vram_cs),
        .frame_addr (frame_addr),
        .frame_data (frame_data)
    );

    obj_line_table u_line_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .vrender1   (vrender1),
        .frame_data (frame_data),
        .frame_addr (frame_addr),
        .line_addr  (line_addr),
        .line_data  (line_data)
    );

    obj_draw u_draw (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .line_addr (line_addr),
        .line_data (line_data),
        .rom_addr  (rom_addr),
        .rom_half  (rom_half),
        .rom_data  (rom_data),
        .rom_cs    (rom_cs),
        .rom_ok    (rom_ok),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data),
        .buf_wr    (buf_wr)
    );

    obj_line_buffer u_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .vdump_odd (vdump[0]),   // buffer half follows line parity
        .hdump     (hdump),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data),
        .buf_wr    (buf_wr),
        .pxl       (pxl)
    );

endmodule

// ==== obj/obj_draw.sv ====
// object drawer, fetches tile rows from rom and writes the line buffer
`timescale 1ns/1ps

module obj_draw (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    output obj_pkg::line_addr_t line_addr,
    input  obj_pkg::vram_word_t line_data,
    output obj_pkg::rom_addr_t  rom_addr,
    output logic                rom_half,
    input  obj_pkg::rom_word_t  rom_data,
    output logic                rom_cs,
    input  logic                rom_ok,
    output obj_pkg::hpos_t      buf_addr,
    output obj_pkg::pxl_t       buf_data,
    output logic                buf_wr
);
    import obj_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,   // four entry words
        FETCH,  // rom row half
        WRITE   // eight pixels
    } state_t;

    state_t     state;
    logic       half;     // list half, opposite of the line table
    logic [4:0] entry;
    logic [2:0] wcnt;     // read step
    logic [1:0] wsel;
    logic       second;   // right half of the tile
    logic [2:0] pcnt;     // pixel in the word
    hpos_t      x;
    logic [3:0] row;
    vram_word_t code;
    logic [4:0] pal;
    logic       hflip;
    rom_word_t  pix;      // pixel shifter
    logic [3:0] color;

    assign wsel      = wcnt[1:0] - 2'd1;
    assign line_addr = {half, entry, wcnt[1:0]};

    assign rom_addr = {code, row};
    assign rom_half = second ^ hflip;  // mirrored halves under hflip
    assign rom_cs   = state == FETCH;

    assign color    = hflip ? pix[31:28] : pix[3:0];
    assign buf_addr = x + hpos_t'({second, pcnt});  // wraps at 512
    assign buf_data = {pal, color};
    assign buf_wr   = state == WRITE && color != TRANSP_COLOR;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            half   <= 1'b1;  // first start flips to the unwritten half
            entry  <= '0;
            wcnt   <= '0;
            second <= 1'b0;
            pcnt   <= '0;
        end else if (start) begin
            half  <= ~half;
            entry <= '0;
            wcnt  <= '0;
            state <= READ;
        end else begin
            case (state)
                READ: begin
                    wcnt <= wcnt + 1'b1;
                    if (wcnt == 3'd4) begin  // attr word arriving
                        second <= 1'b0;
                        state  <= line_data[15:8] == END_ATTR ? IDLE : FETCH;
                    end
                end
                FETCH: begin
                    pcnt <= '0;
                    if (rom_ok) state <= WRITE;
                end
                WRITE: begin
                    pcnt <= pcnt + 1'b1;
                    if (pcnt == 3'd7) begin
                        if (!second) begin
                            second <= 1'b1;
                            state  <= FETCH;
                        end else if (entry == 5'(LINE_OBJ - 1)) begin
                            state <= IDLE;   // list full
                        end else begin
                            entry <= entry + 1'b1;
                            wcnt  <= '0;
                            state <= READ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // entry payload and pixel shifter
    always_ff @(posedge clk) begin
        if (state == READ && wcnt != 3'd0) begin
            case (wsel)
                WORD_X:    x    <= line_data[8:0];
                WORD_Y:    row  <= line_data[3:0];  // row already flipped
                WORD_CODE: code <= line_data;
                default: begin
                    pal   <= line_data[4:0];
                    hflip <= line_data[5];
                end
            endcase
        end
        if (state == FETCH && rom_ok) pix <= rom_data;
        else if (state == WRITE) pix <= hflip ? pix << 4 : pix >> 4;
    end

endmodule

// ==== obj/obj_frame_table.sv ====
// object frame table, copies the vram object table at vertical blank
`timescale 1ns/1ps

module obj_frame_table (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 vb,
    input  obj_pkg::vram_word_t  vram_base,
    input  obj_pkg::vram_word_t  vram_data,
    input  logic                 vram_ok,
    output obj_pkg::vram_addr_t  vram_addr,
    output logic                 vram_cs,
    input  obj_pkg::frame_addr_t frame_addr,
    output obj_pkg::vram_word_t  frame_data
);
    import obj_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,  // words over the vram handshake
        FILL    // end markers after the table end
    } state_t;

    state_t      state;
    logic        vb_l;      // vb edge detect
    frame_addr_t wr_addr;   // word being copied
    logic        wr_en;
    vram_word_t  wr_data;
    logic        last_word;
    logic        end_seen;
    vram_word_t  mem [FRAME_WORDS];

    assign vram_cs   = state == FETCH;
    assign vram_addr = {vram_base[15:9], wr_addr};  // base sets the upper bits
    assign last_word = wr_addr == frame_addr_t'(FRAME_WORDS - 1);
    assign end_seen  = wr_addr[1:0] == WORD_ATTR && vram_data[15:8] == END_ATTR;

    assign wr_en   = (state == FETCH && vram_ok) || state == FILL;
    assign wr_data = state == FILL ? END_WORD : vram_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            vb_l    <= 1'b0;
            wr_addr <= '0;
        end else begin
            vb_l <= vb;
            case (state)
                IDLE: begin
                    if (vb && !vb_l) begin  // rising edge of vb
                        state   <= FETCH;
                        wr_addr <= '0;
                    end
                end
                FETCH: begin
                    if (vram_ok) begin      // word taken this clock
                        if (last_word) begin
                            state <= IDLE;
                        end else begin
                            wr_addr <= wr_addr + 1'b1;  // next address a clock later
                            if (end_seen) state <= FILL;
                        end
                    end
                end
                FILL: begin
                    if (last_word) state <= IDLE;
                    else wr_addr <= wr_addr + 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // table ram, one write port and a registered read for the line table
    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
        frame_data <= mem[frame_addr];
    end

endmodule

// ==== obj/obj_line_buffer.sv ====
// object line buffer, ping-pong halves written by the drawer and read out
`timescale 1ns/1ps

module obj_line_buffer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           pxl_cen,
    input  logic           vdump_odd,
    input  obj_pkg::hpos_t hdump,
    input  obj_pkg::hpos_t buf_addr,
    input  obj_pkg::pxl_t  buf_data,
    input  logic           buf_wr,
    output obj_pkg::pxl_t  pxl
);
    import obj_pkg::*;

    pxl_t rd [2];  // pixel at hdump in each half

    for (genvar h = 0; h < 2; h++) begin : g_half
        pxl_t mem [512];
        logic shown;

        assign shown = vdump_odd == 1'(h);  // half on screen now

        always_ff @(posedge clk) begin
            if (shown && pxl_cen) mem[hdump] <= BLANK_PXL;  // erase once read
            else if (!shown && buf_wr) mem[buf_addr] <= buf_data;
        end

        assign rd[h] = mem[hdump];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) pxl <= BLANK_PXL;
        else if (pxl_cen) pxl <= rd[vdump_odd];
    end

endmodule

// ==== obj/obj_line_table.sv ====
// object line table, lists the objects that cover the render line
`timescale 1ns/1ps

module obj_line_table (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  obj_pkg::vpos_t       vrender1,
    input  obj_pkg::vram_word_t  frame_data,
    output obj_pkg::frame_addr_t frame_addr,
    input  obj_pkg::line_addr_t  line_addr,
    output obj_pkg::vram_word_t  line_data
);
    import obj_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SCAN_A,  // attr address out, Y of prev object back
        SCAN_Y,  // Y address out, attr back
        COPY,    // four words into the list
        FINISH   // end entry
    } state_t;

    state_t     state;
    logic [7:0] idx;         // object being scanned
    logic [7:0] prev;        // object whose Y is arriving
    logic       vld;         // frame_data holds Y of prev
    logic       last;        // prev is the final table object
    logic       half;        // list half being written
    logic [5:0] cnt;         // entries written
    logic [2:0] wcnt;        // copy step
    logic [1:0] wsel;
    logic       vflip;
    logic [3:0] row;
    vpos_t      dy;
    logic       hit;
    logic       wr_en;
    line_addr_t wr_addr;
    vram_word_t wr_data;
    vram_word_t list_mem [256];

    assign dy   = vrender1 - frame_data[8:0];
    assign hit  = vld && dy[8:4] == 5'd0;   // within 16 lines below Y
    assign wsel = wcnt[1:0] - 2'd1;         // word arriving now

    always_comb begin
        frame_addr = {idx, WORD_ATTR};
        wr_en      = 1'b0;
        wr_addr    = {half, cnt[4:0], wsel};
        wr_data    = frame_data;
        case (state)
            SCAN_Y: frame_addr = {idx, WORD_Y};
            COPY: begin
                frame_addr = {prev, wcnt[1:0]};
                wr_en      = wcnt != 3'd0;
                if (wsel == WORD_Y) wr_data = {12'd0, row};  // row replaces Y
            end
            FINISH: begin
                wr_en   = cnt != 6'(LINE_OBJ);    // full list needs no marker
                wr_addr = {half, cnt[4:0], WORD_ATTR};
                wr_data = END_WORD;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            idx   <= '0;
            prev  <= '0;
            vld   <= 1'b0;
            last  <= 1'b0;
            half  <= 1'b0;
            cnt   <= '0;
            wcnt  <= '0;
            vflip <= 1'b0;
            row   <= '0;
        end else if (start) begin
            half  <= ~half;  // list halves swap each line
            state <= SCAN_A;
            idx   <= '0;
            vld   <= 1'b0;
            last  <= 1'b0;
            cnt   <= '0;
        end else begin
            case (state)
                SCAN_A: begin
                    row  <= dy[3:0] ^ {4{vflip}};  // vertical flip applied here
                    wcnt <= '0;
                    if (hit) state <= COPY;
                    else if (last) state <= FINISH;
                    else state <= SCAN_Y;
                end
                SCAN_Y: begin
                    vflip <= frame_data[6];
                    prev  <= idx;
                    vld   <= 1'b1;
                    if (frame_data[15:8] == END_ATTR) begin
                        state <= FINISH;
                    end else begin
                        last  <= idx == 8'(MAX_OBJ - 1);
                        idx   <= idx + 1'b1;
                        state <= SCAN_A;
                    end
                end
                COPY: begin
                    wcnt <= wcnt + 1'b1;
                    if (wcnt == 3'd4) begin
                        cnt <= cnt + 1'b1;
                        vld <= 1'b0;     // attr of idx read again
                        if (last || cnt == 6'(LINE_OBJ - 1)) state <= FINISH;
                        else state <= SCAN_A;
                    end
                end
                FINISH: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // list ram, drawer reads the other half
    always_ff @(posedge clk) begin
        if (wr_en) list_mem[wr_addr] <= wr_data;
        line_data <= list_mem[line_addr];
    end

endmodule

// ==== sources.f ====
common/obj_pkg.sv
obj/obj_frame_table.sv
obj/obj_line_table.sv
obj/obj_draw.sv
obj/obj_line_buffer.sv
design/obj_engine.sv
testbench/obj_engine_checker.sv
testbench/obj_engine_tb.sv

// ==== testbench/obj_engine_checker.sv ====
// object engine checker, vram and rom handshake and reset state assertions
`timescale 1ns/1ps

module obj_engine_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                vb,
    input obj_pkg::vram_word_t vram_base,
    input obj_pkg::vram_addr_t vram_addr,
    input logic                vram_cs,
    input logic                vram_ok,
    input obj_pkg::rom_addr_t  rom_addr,
    input logic                rom_half,
    input logic                rom_cs,
    input logic                rom_ok,
    input obj_pkg::pxl_t       pxl
);
    import obj_pkg::*;

    int unsigned fail_cnt = 0;  // read by the testbench summary

    // copy opens on the clock after a vb rising edge
    a_vram_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(vram_cs) |-> $past(vb) && !$past(vb, 2))
        else begin $error("vram_cs rose without a vb edge"); fail_cnt++; end

    a_vram_base: assert property (@(posedge clk) disable iff (!rst_n)
        vram_cs |-> vram_addr[16:10] == vram_base[15:9])  // base upper bits
        else begin $error("vram_addr upper bits differ from vram_base"); fail_cnt++; end

    a_vram_hold: assert property (@(posedge clk) disable iff (!rst_n)
        vram_cs && !vram_ok |=> vram_cs && $stable(vram_addr))
        else begin $error("vram request moved before vram_ok"); fail_cnt++; end

    // one step per accepted word, unless the copy ended
    a_vram_step: assert property (@(posedge clk) disable iff (!rst_n)
        vram_cs && vram_ok |=> !vram_cs || vram_addr[9:0] == $past(vram_addr[9:0]) + 10'd1)
        else begin $error("vram_addr did not step after an accepted word"); fail_cnt++; end

    // a new line may drop rom_cs, the address still holds that clock
    a_rom_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cs && !rom_ok |=> $stable(rom_addr) && $stable(rom_half))
        else begin $error("rom request moved before rom_ok"); fail_cnt++; end

    a_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !vram_cs && !rom_cs && pxl == BLANK_PXL)
        else begin $error("outputs not idle when reset ended"); fail_cnt++; end

endmodule

// ==== testbench/obj_engine_tb.sv ====
// object engine testbench with video timing, vram and rom models and a pixel scoreboard
`timescale 1ns/1ps

module obj_engine_tb;
    import obj_pkg::*;

    localparam int H_TOTAL    = 256;  // pixels per line, two clocks each
    localparam int V_TOTAL    = 40;
    localparam int VB_LINE    = 32;   // first blank line
    localparam int N_OBJ      = 5;    // objects before the end marker
    localparam int LAST_FRAME = 3;    // frames 1 and 2 are compared
    localparam int FRAME_CLKS = 2 * H_TOTAL * V_TOTAL;

    logic        clk;
    logic        rst_n;
    logic        pxl_cen;
    logic        vb;
    logic        start;
    vpos_t       vrender1;
    vpos_t       vdump;
    hpos_t       hdump;
    vram_word_t  vram_base;
    vram_addr_t  vram_addr;
    vram_word_t  vram_data;
    logic        vram_ok;
    logic        vram_cs;
    rom_addr_t   rom_addr;
    logic        rom_half;
    rom_word_t   rom_data;
    logic        rom_cs;
    logic        rom_ok;
    pxl_t        pxl;

    vram_word_t  table_mem [24];  // x, y, code, attr per object
    int          seed;
    int          vram_wait;
    int          rom_wait;
    int          line_clk;         // clock within the line
    int          vline;
    int          frame;
    int          pixel_err;
    int          timeout_cnt;
    int          other_err;
    int          checked;
    int          drawn;            // object pixels shown correctly by the DUT
    int          f;
    int          total_err;
    logic        ok;

    obj_engine UUT (.*);

    bind obj_engine obj_engine_checker u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .vb        (vb),
        .vram_base (vram_base),
        .vram_addr (vram_addr),
        .vram_cs   (vram_cs),
        .vram_ok   (vram_ok),
        .rom_addr  (rom_addr),
        .rom_half  (rom_half),
        .rom_cs    (rom_cs),
        .rom_ok    (rom_ok),
        .pxl       (pxl)
    );

    always #10 clk = ~clk;

    // nibble n of a row half: low code bits + row + pixel column in the tile
    function automatic rom_word_t rom_word(input rom_addr_t addr, input logic half);
        rom_word_t w;
        int        n;
        for (n = 0; n < 8; n++) begin
            w[4*n +: 4] = addr[7:4] + addr[3:0] + 4'(n) + (half ? 4'd8 : 4'd0);
        end
        return w;
    endfunction

    // scoreboard pixel, later objects in the table win
    function automatic pxl_t expect_pxl(input vpos_t v, input hpos_t h);
        pxl_t       res;
        vpos_t      dy;
        hpos_t      dx;
        logic [3:0] row;
        logic [3:0] col;
        logic [3:0] colour;
        vram_word_t attr;
        int         i;
        res = BLANK_PXL;
        for (i = 0; i < N_OBJ; i++) begin
            attr = table_mem[4*i+3];
            dy   = v - table_mem[4*i+1][8:0];  // 9 bit wrap
            dx   = h - table_mem[4*i][8:0];
            if (dy < 9'd16 && dx < 9'd16) begin
                row    = attr[6] ? 4'd15 - dy[3:0] : dy[3:0];  // vflip
                col    = attr[5] ? 4'd15 - dx[3:0] : dx[3:0];  // hflip
                colour = table_mem[4*i+2][3:0] + row + col;
                if (colour != TRANSP_COLOR) res = {attr[4:0], colour};
            end
        end
        return res;
    endfunction

    // video timing and pixel compare, compare first with last clock's values
    always @(negedge clk) begin : video_timing
        pxl_t want;
        if (pxl_cen && frame >= 1 && frame < LAST_FRAME) begin
            want = expect_pxl(vdump, hdump);
            checked++;
            if (want != BLANK_PXL && pxl == want) drawn++;
            assert (pxl == want)
            else begin
                $display("Fail %0t: line %0d column %0d shows %h, expected %h",
                         $time, vdump, hdump, pxl, want);
                pixel_err++;
            end
        end
        if (line_clk == 2 * H_TOTAL - 1) begin
            line_clk = 0;
            if (vline == V_TOTAL - 1) begin
                vline = 0;
                frame++;
            end else begin
                vline++;
            end
        end else begin
            line_clk++;
        end
        pxl_cen  = line_clk % 2 == 0;  // every second clock
        hdump    = hpos_t'(line_clk / 2);
        vdump    = vpos_t'(vline);
        vrender1 = vpos_t'((vline + 2) % V_TOTAL);
        start    = line_clk == 0;
        vb       = vline >= VB_LINE;
    end

    // vram and rom models, one block so the random delays draw in a fixed order
    always @(negedge clk) begin : memory_models
        if (vram_ok) begin
            vram_ok   = 1'b0;
            vram_wait = $random(seed) & 3;
        end else if (vram_cs) begin
            if (vram_wait == 0) begin
                vram_ok   = 1'b1;
                vram_data = vram_addr[9:0] < 10'd24 ? table_mem[vram_addr[4:0]] : '0;
            end else begin
                vram_wait--;
            end
        end
        if (rom_ok) begin
            rom_ok   = 1'b0;
            rom_wait = $random(seed) & 3;
        end else if (rom_cs) begin
            if (rom_wait == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_word(rom_addr, rom_half);
            end else begin
                rom_wait--;
            end
        end
    end

    task automatic wait_vram_cs(input logic level, input int limit, output logic done);
        int n;
        n = 0;
        while (vram_cs !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        done = vram_cs === level;
        if (!done) begin
            $display("timeout: vram_cs did not go %0b within %0d clocks", level, limit);
            timeout_cnt++;
        end
    endtask

    task automatic wait_frame(input int target, input int limit, output logic done);
        int n;
        n = 0;
        @(posedge clk);
        while (frame < target && n < limit) begin
            @(posedge clk);
            n++;
        end
        done = frame >= target;
        if (!done) begin
            $display("timeout: frame %0d was not reached within %0d clocks", target, limit);
            timeout_cnt++;
        end
    endtask

    initial begin
        seed      = 5;
        clk       = 1'b0;
        rst_n     = 1'b0;
        pxl_cen   = 1'b0;
        vb        = 1'b0;
        start     = 1'b0;
        vrender1  = '0;
        vdump     = '0;
        hdump     = '0;
        vram_base = 16'h2A00;  // upper bits land on vram_addr 16:10
        vram_data = '0;
        vram_ok   = 1'b0;
        rom_data  = '0;
        rom_ok    = 1'b0;
        vram_wait = 0;
        rom_wait  = 0;
        line_clk  = 2 * H_TOTAL - 1;  // first negedge opens line 0 of frame 0
        vline     = V_TOTAL - 1;
        frame     = -1;
        pixel_err = 0;
        timeout_cnt = 0;
        other_err = 0;
        checked   = 0;
        drawn     = 0;
        table_mem = '{
            16'd10,  16'd4,   16'h0003, 16'h0002,  // plain, palette 2
            16'd18,  16'd10,  16'h0025, 16'h0025,  // hflip, overlaps object 0
            16'd100, 16'd20,  16'h0107, 16'h0049,  // vflip, runs into blank lines
            16'd200, 16'd300, 16'h0009, 16'h0001,  // below the frame, never shown
            16'd24,  16'd14,  16'h000C, 16'h0071,  // both flips on top of object 1
            16'd0,   16'd0,   16'h0000, 16'hFF00   // end marker
        };

        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // one table copy per frame, then run out frame 2
        ok = 1'b1;
        for (f = 0; f < LAST_FRAME && ok; f++) begin
            wait_vram_cs(1'b1, 2 * FRAME_CLKS, ok);
            if (ok) wait_vram_cs(1'b0, FRAME_CLKS, ok);
        end
        if (ok) wait_frame(LAST_FRAME, 2 * FRAME_CLKS, ok);

        assert (checked > 0)
        else begin
            $display("no displayed pixel was compared");
            other_err++;
        end
        assert (drawn > 0)
        else begin
            $display("no object pixel was shown correctly");
            other_err++;
        end

        total_err = pixel_err + timeout_cnt + other_err + int'(UUT.u_chk.fail_cnt);
        $display("summary: pixel errors %0d, assertion failures %0d, timeouts %0d, other %0d",
                 pixel_err, UUT.u_chk.fail_cnt, timeout_cnt, other_err);
        if (total_err == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
